// ==== sim/xbar_golden.txt ====
// test master cmd(0 read 1 write) address wdata rdata
// rdata is the master read register after the transfer
1 0 1 C0000010 11110000 00000000
1 1 1 80000011 22220001 00000000
1 2 1 40000012 33330002 00000000
1 3 1 00000013 44440003 00000000
2 1 0 C0000010 00000000 11110000
2 3 0 40000012 00000000 33330002
3 0 1 C0000020 A5A50100 00000000
3 0 0 C0000020 00000000 A5A50100
3 0 1 80000021 A5A50101 A5A50100
3 0 0 80000021 00000000 A5A50101
3 0 1 40000022 A5A50102 A5A50101
3 0 0 40000022 00000000 A5A50102
3 0 1 00000023 A5A50103 A5A50102
3 0 0 00000023 00000000 A5A50103
4 2 1 3ABCDE24 DEC00024 00000000
4 1 1 F0000005 5555AAAA 11110000
4 2 0 3ABCDE24 00000000 DEC00024
4 1 0 F0000005 00000000 5555AAAA
5 0 0 80000011 00000000 22220001
5 1 0 00000013 00000000 44440003
5 2 1 80000030 600D0030 DEC00024
5 3 1 C0000031 600D0031 33330002
5 0 0 C0000031 00000000 600D0031
5 1 0 80000030 00000000 600D0030
5 2 0 40000012 00000000 33330002
5 3 0 C0000000 00000000 00000000
5 3 1 40000032 77770032 00000000
5 0 1 00000033 88880033 600D0031
5 0 0 40000032 00000000 77770032
5 3 0 00000033 00000000 88880033

// ==== src.f ====
common/bus_pkg.sv
common/xbar_pkg.sv
verilog/rr_arbiter.sv
verilog/xbar_ctrl.sv
verilog/req_router.sv
verilog/resp_collector.sv
verilog/xbar_top.sv
sim/tb_slave_model.sv
sim/xbar_sva.sv
sim/tb_xbar_top.sv

// ==== sim/tb_xbar_top.sv ====
`default_nettype none

module tb_xbar_top;
	timeunit 1ns;
	timeprecision 1ps;

	import bus_pkg::*;
	import xbar_pkg::*;

	localparam int ACK_DELAY_MAX = 3;             // Longest slave stall
	localparam int TIMEOUT_MULT  = 2;             // Margin on the expected run length
	localparam int RESET_CYCLES  = 16;
	localparam int GOLD_LINES    = 64;            // Room in the golden buffer
	localparam int GOLD_COLS     = 6;             // test master cmd addr wdata rdata

	logic                       iClk;
	logic                       rst_n;
	logic [NUM_MASTERS-1:0]     master_req;
	bus_cmd_e                   master_cmd   [NUM_MASTERS];
	bus_addr_u                  master_addr  [NUM_MASTERS];
	bus_data_t                  master_wdata [NUM_MASTERS];
	bus_data_t                  master_rdata [NUM_MASTERS];
	logic [NUM_MASTERS-1:0]     master_ack;
	logic [NUM_SLAVES-1:0]      slave_req;
	bus_cmd_e                   slave_cmd    [NUM_SLAVES];
	bus_offset_t                slave_addr   [NUM_SLAVES];
	bus_data_t                  slave_wdata  [NUM_SLAVES];
	wire logic [NUM_SLAVES-1:0] slave_ack;
	wire bus_data_t             slave_rdata  [NUM_SLAVES];

	logic [31:0] golden [GOLD_LINES*GOLD_COLS];   // Flat copy of the golden file
	int          n_lines;                         // Transfers in the golden file
	int          err_cnt;
	int          check_cnt;
	int          ack_cnt;                         // master_ack pulses seen
	int          run_cycles;                      // Cycles since reset release
	int          timeout_limit;
	port_idx_t   last_served;                     // Round-robin pointer model
	int          req_slave;                       // Slave seen with slave_req high
	bus_offset_t req_addr;
	bus_cmd_e    req_cmd;
	bus_data_t   req_wdata;

	xbar_top dut (.*);

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		tb_slave_model #(.MAX_DELAY(ACK_DELAY_MAX)) u_slave (
			.iClk  (iClk),
			.rst_n (rst_n),
			.req   (slave_req[s]),
			.cmd   (slave_cmd[s]),
			.addr  (slave_addr[s]),
			.wdata (slave_wdata[s]),
			.ack   (slave_ack[s]),
			.rdata (slave_rdata[s])
		);
	end

	initial begin
		iClk = 1'b0;
		forever #50 iClk = ~iClk;
	end

	function automatic logic [31:0] golden_field(input int idx, input int col);
		return golden[idx * GOLD_COLS + col];
	endfunction

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// Slave side of the finished transfer against the decode rule
	task automatic check_transfer(input int idx, input port_idx_t m);
		logic [31:0] addr;
		string       tag;
		addr = golden_field(idx, 3);
		tag  = $sformatf("test %0d master %0d", golden_field(idx, 0), m);
		compare_value({tag, " target slave"}, req_slave, 32'(3 - addr[31:30]));
		compare_value({tag, " slave offset"}, req_addr, addr[29:0]);
		compare_value({tag, " slave command"}, req_cmd, golden_field(idx, 2));
		if (golden_field(idx, 2) != 0) begin
			compare_value({tag, " slave write data"}, req_wdata, golden_field(idx, 4));
		end
		compare_value({tag, " read data"}, master_rdata[m], golden_field(idx, 5));
		req_slave = -1;                           // Next transfer shows its own request
	endtask

	// Lines first..last-1 request together, one per master
	task automatic run_batch(input int first, input int last);
		logic [NUM_MASTERS-1:0] pending;
		port_idx_t              m;
		port_idx_t              exp_m;
		int                     line_of [NUM_MASTERS];
		pending = '0;
		for (int k = first; k < last; k++) begin
			m               = port_idx_t'(golden_field(k, 1));
			line_of[m]      = k;
			pending[m]      = 1'b1;
			master_cmd[m]   = (golden_field(k, 2) != 0) ? CMD_WRITE : CMD_READ;
			master_addr[m]  = golden_field(k, 3);
			master_wdata[m] = golden_field(k, 4);
			master_req[m]   = 1'b1;
		end
		while (pending != '0) begin
			@(negedge iClk);
			if (master_ack != '0) begin
				exp_m = port_idx_t'(last_served + 1'b1);  // Search after the last winner
				while (!pending[exp_m]) begin
					exp_m = exp_m + 1'b1;
				end
				for (int k = NUM_MASTERS - 1; k >= 0; k--) begin
					if (master_ack[k]) begin
						m = port_idx_t'(k);
					end
				end
				if (!$onehot(master_ack)) begin
					$display("Error at %0t: several masters acknowledged at once", $time);
					err_cnt++;
				end
				compare_value("acknowledged master", m, exp_m);
				if (pending[m]) begin
					check_transfer(line_of[m], m);
					master_req[m] = 1'b0;           // Drop req after seeing ack
					pending[m]    = 1'b0;
					last_served   = m;
				end else begin
					$display("Error at %0t: master %0d acknowledged without a request", $time, m);
					err_cnt++;
				end
			end
		end
	endtask

	// Slave request capture and start-up window watch
	always @(negedge iClk) begin
		if (rst_n) begin
			for (int s = 0; s < NUM_SLAVES; s++) begin
				if (slave_req[s]) begin
					req_slave = s;
					req_addr  = slave_addr[s];
					req_cmd   = slave_cmd[s];
					req_wdata = slave_wdata[s];
				end
			end
			if (master_ack != '0) begin
				ack_cnt += $countones(master_ack);
				if (run_cycles < INIT_DELAY) begin
					$display("Error at %0t: master_ack before the start-up delay ended", $time);
					err_cnt++;
				end
			end
		end
	end

	always @(posedge iClk) begin
		if (rst_n) begin
			run_cycles++;
			if (run_cycles > timeout_limit) begin
				$display("Timeout: the run hung and did not end within %0d cycles", timeout_limit);
				$display("Finished with errors");
				$finish;
			end
		end
	end

	initial begin
		int                     i;
		int                     j;
		int                     tnum;
		int                     t_err;
		int                     t_cnt;
		int                     n_tests;
		logic [NUM_MASTERS-1:0] used;
		void'($urandom(32'h73a084be));
		rst_n      = 1'b0;
		master_req = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			master_cmd[m]   = CMD_READ;
			master_addr[m]  = '0;
			master_wdata[m] = '0;
		end
		err_cnt     = 0;
		check_cnt   = 0;
		ack_cnt     = 0;
		run_cycles  = 0;
		n_tests     = 0;
		req_slave   = -1;
		last_served = port_idx_t'(NUM_MASTERS - 1);  // Master 0 is first after reset
		$readmemh("sim/xbar_golden.txt", golden);
		n_lines = 0;
		while (n_lines < GOLD_LINES && !$isunknown(golden_field(n_lines, 0))) begin
			n_lines++;
		end
		timeout_limit = (INIT_DELAY + n_lines * (4 + ACK_DELAY_MAX)) * TIMEOUT_MULT;
		repeat (RESET_CYCLES) @(negedge iClk);
		rst_n = 1'b1;
		i     = 0;
		while (i < n_lines) begin
			tnum  = golden_field(i, 0);
			t_err = err_cnt;
			t_cnt = 0;
			while (i < n_lines && golden_field(i, 0) == tnum) begin
				j    = i;
				used = '0;
				while (j < n_lines && golden_field(j, 0) == tnum && !used[golden_field(j, 1)]) begin
					used[golden_field(j, 1)] = 1'b1;  // A repeated master starts a new batch
					j++;
				end
				if (i > 0) begin
					@(negedge iClk);
				end
				run_batch(i, j);
				t_cnt += j - i;
				i = j;
			end
			n_tests++;
			$display("Test %0d finished: %0d transfers, %0d errors", tnum, t_cnt, err_cnt - t_err);
		end
		@(posedge iClk);
		if (ack_cnt != n_lines) begin
			$display("Error: %0d master acknowledges for %0d transfers", ack_cnt, n_lines);
			err_cnt++;
		end
		$display("Summary: %0d tests, %0d transfers, %0d checks, %0d errors",
			n_tests, n_lines, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/xbar_sva.sv ====
`default_nettype none

module xbar_sva (
	input wire logic                             iClk,
	input wire logic                             rst_n,
	input wire logic [xbar_pkg::NUM_MASTERS-1:0] master_ack,
	input wire logic [xbar_pkg::NUM_SLAVES-1:0]  slave_req,
	input wire logic [xbar_pkg::NUM_SLAVES-1:0]  slave_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	import xbar_pkg::*;

	ack_pulse: assert property (@(posedge iClk) disable iff (!rst_n)
		(|master_ack) |=> (master_ack == '0))
		else $error("master_ack held for more than one cycle");

	// One transaction at a time on the shared bus
	one_slave: assert property (@(posedge iClk) disable iff (!rst_n) $onehot0(slave_req))
		else $error("several slave_req lines high together");

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_hold
		req_hold: assert property (@(posedge iClk) disable iff (!rst_n)
			(slave_req[s] && !slave_ack[s]) |=> slave_req[s])
			else $error("slave_req %0d dropped before slave_ack", s);
	end

endmodule

bind xbar_top xbar_sva u_sva (
	.iClk       (iClk),
	.rst_n      (rst_n),
	.master_ack (master_ack),
	.slave_req  (slave_req),
	.slave_ack  (slave_ack)
);

`default_nettype wire

// ==== sim/tb_slave_model.sv ====
`default_nettype none

module tb_slave_model #(
	parameter int MAX_DELAY = 3                   // Longest ack stall in cycles
) (
	input  wire logic                 iClk,
	input  wire logic                 rst_n,
	input  wire logic                 req,        // Request from the interconnect
	input  wire bus_pkg::bus_cmd_e    cmd,
	input  wire bus_pkg::bus_offset_t addr,       // Slave-local offset
	input  wire bus_pkg::bus_data_t   wdata,
	output logic                      ack,        // One-cycle done strobe
	output bus_pkg::bus_data_t        rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	import bus_pkg::*;

	bus_data_t mem [64];    // Word store indexed by low offset bits
	logic      active;      // Stall countdown running
	int        wait_cnt;    // Cycles left before ack

	initial begin
		ack   = 1'b0;
		rdata = '0;
		for (int w = 0; w < 64; w++) begin
			mem[w] = '0;                          // Empty memory
		end
	end

	// Outputs change on the falling edge
	always @(negedge iClk or negedge rst_n) begin
		int delay;
		if (!rst_n) begin
			ack      <= 1'b0;
			rdata    <= '0;
			active   <= 1'b0;
			wait_cnt <= 0;
		end else if (ack) begin
			ack    <= 1'b0;                       // req already dropped on the ack edge
			active <= 1'b0;
		end else if (req) begin
			delay = active ? wait_cnt : int'($urandom_range(MAX_DELAY, 0));
			if (delay == 0) begin
				ack   <= 1'b1;
				rdata <= mem[addr[5:0]];
				if (cmd == CMD_WRITE) begin
					mem[addr[5:0]] <= wdata;
				end
			end else begin
				active   <= 1'b1;                 // Back-pressure for a few cycles
				wait_cnt <= delay - 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/xbar_top.sv ====
`default_nettype none

module xbar_top (
	input  wire logic                                  iClk,
	input  wire logic                                  rst_n,

	input  wire logic [xbar_pkg::NUM_MASTERS-1:0]      master_req,    // Master requests
	input  wire bus_pkg::bus_cmd_e   master_cmd   [xbar_pkg::NUM_MASTERS],
	input  wire bus_pkg::bus_addr_u  master_addr  [xbar_pkg::NUM_MASTERS],
	input  wire bus_pkg::bus_data_t  master_wdata [xbar_pkg::NUM_MASTERS],
	output bus_pkg::bus_data_t       master_rdata [xbar_pkg::NUM_MASTERS],
	output logic [xbar_pkg::NUM_MASTERS-1:0]           master_ack,    // One-cycle done pulses

	output logic [xbar_pkg::NUM_SLAVES-1:0]            slave_req,     // Slave requests
	output bus_pkg::bus_cmd_e        slave_cmd    [xbar_pkg::NUM_SLAVES],
	output bus_pkg::bus_offset_t     slave_addr   [xbar_pkg::NUM_SLAVES],
	output bus_pkg::bus_data_t       slave_wdata  [xbar_pkg::NUM_SLAVES],
	input  wire logic [xbar_pkg::NUM_SLAVES-1:0]       slave_ack,     // Slave done strobes
	input  wire bus_pkg::bus_data_t  slave_rdata  [xbar_pkg::NUM_SLAVES]
);
	import bus_pkg::*;
	import xbar_pkg::*;

	logic      grant_valid;     // Some master is asking
	port_idx_t grant_idx;       // Round-robin winner
	logic      grant_load;      // Take the winner this cycle
	port_idx_t tgt_idx;         // Decoded slave of the latched request
	port_idx_t owner_idx;       // Master that owns the transaction
	logic      slave_start;     // Raise the slave request
	logic      slave_done;      // Target slave acknowledged
	logic      resp_fire;       // Acknowledge the owner
	bus_cmd_e  cur_cmd;         // Latched command

	xbar_ctrl u_ctrl (
		.iClk        (iClk),
		.rst_n       (rst_n),
		.master_req  (master_req),
		.grant_valid (grant_valid),
		.grant_idx   (grant_idx),
		.tgt_idx     (tgt_idx),
		.slave_ack   (slave_ack),
		.grant_load  (grant_load),
		.slave_start (slave_start),
		.slave_done  (slave_done),
		.resp_fire   (resp_fire),
		.owner_idx   (owner_idx)
	);

	rr_arbiter u_arb (
		.iClk        (iClk),
		.rst_n       (rst_n),
		.master_req  (master_req),
		.grant_load  (grant_load),
		.grant_valid (grant_valid),
		.grant_idx   (grant_idx)
	);

	req_router u_router (
		.iClk         (iClk),
		.rst_n        (rst_n),
		.grant_load   (grant_load),
		.grant_idx    (grant_idx),
		.master_cmd   (master_cmd),
		.master_addr  (master_addr),
		.master_wdata (master_wdata),
		.slave_start  (slave_start),
		.slave_done   (slave_done),
		.tgt_idx      (tgt_idx),
		.cur_cmd      (cur_cmd),
		.slave_req    (slave_req),
		.slave_cmd    (slave_cmd),
		.slave_addr   (slave_addr),
		.slave_wdata  (slave_wdata)
	);

	resp_collector u_resp (
		.iClk         (iClk),
		.rst_n        (rst_n),
		.owner_idx    (owner_idx),
		.tgt_idx      (tgt_idx),
		.cur_cmd      (cur_cmd),
		.slave_done   (slave_done),
		.resp_fire    (resp_fire),
		.slave_rdata  (slave_rdata),
		.master_rdata (master_rdata),
		.master_ack   (master_ack)
	);

endmodule

`default_nettype wire

// ==== verilog/resp_collector.sv ====
`default_nettype none

module resp_collector (
	input  wire logic                 iClk,
	input  wire logic                 rst_n,
	input  wire xbar_pkg::port_idx_t  owner_idx,    // Master waiting for the answer
	input  wire xbar_pkg::port_idx_t  tgt_idx,      // Slave that answers
	input  wire bus_pkg::bus_cmd_e    cur_cmd,      // Read or write in flight
	input  wire logic                 slave_done,   // Target acknowledged
	input  wire logic                 resp_fire,    // Acknowledge the owner
	input  wire bus_pkg::bus_data_t   slave_rdata  [xbar_pkg::NUM_SLAVES],
	output bus_pkg::bus_data_t        master_rdata [xbar_pkg::NUM_MASTERS],
	output logic [xbar_pkg::NUM_MASTERS-1:0] master_ack
);
	import bus_pkg::*;
	import xbar_pkg::*;

	// Read data registers keep their value across writes
	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			for (int m = 0; m < NUM_MASTERS; m++) begin
				master_rdata[m] <= '0;
			end
		end else if (slave_done && (cur_cmd == CMD_READ)) begin
			master_rdata[owner_idx] <= slave_rdata[tgt_idx];  // Sampled on the ack cycle
		end
	end

	// One-cycle ack to the owner only
	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			master_ack <= '0;
		end else begin
			for (int m = 0; m < NUM_MASTERS; m++) begin
				master_ack[m] <= resp_fire && (owner_idx == port_idx_t'(m));
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/req_router.sv ====
`default_nettype none

module req_router (
	input  wire logic                 iClk,
	input  wire logic                 rst_n,
	input  wire logic                 grant_load,   // Latch the winner's request
	input  wire xbar_pkg::port_idx_t  grant_idx,    // Winning master
	input  wire bus_pkg::bus_cmd_e    master_cmd   [xbar_pkg::NUM_MASTERS],
	input  wire bus_pkg::bus_addr_u   master_addr  [xbar_pkg::NUM_MASTERS],
	input  wire bus_pkg::bus_data_t   master_wdata [xbar_pkg::NUM_MASTERS],
	input  wire logic                 slave_start,  // Raise the target request
	input  wire logic                 slave_done,   // Target acknowledged
	output xbar_pkg::port_idx_t       tgt_idx,      // Decoded slave
	output bus_pkg::bus_cmd_e         cur_cmd,      // Latched command
	output logic [xbar_pkg::NUM_SLAVES-1:0] slave_req,
	output bus_pkg::bus_cmd_e         slave_cmd    [xbar_pkg::NUM_SLAVES],
	output bus_pkg::bus_offset_t      slave_addr   [xbar_pkg::NUM_SLAVES],
	output bus_pkg::bus_data_t        slave_wdata  [xbar_pkg::NUM_SLAVES]
);
	import bus_pkg::*;
	import xbar_pkg::*;

	bus_addr_u cur_addr;    // Latched address, raw and decoded
	bus_data_t cur_wdata;   // Latched write data

	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			cur_cmd  <= CMD_READ;
			cur_addr <= '0;
		end else if (grant_load) begin
			cur_cmd      <= master_cmd[grant_idx];
			cur_addr.raw <= master_addr[grant_idx].raw;
		end
	end

	always_ff @(posedge iClk) begin
		if (grant_load) begin
			cur_wdata <= master_wdata[grant_idx];
		end
	end

	// Top address bits pick the slave
	assign tgt_idx = SEL_TO_SLAVE[cur_addr.fields.sel];

	// Request and command per slave, only the target moves
	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			slave_req <= '0;
			for (int s = 0; s < NUM_SLAVES; s++) begin
				slave_cmd[s] <= CMD_READ;
			end
		end else begin
			if (slave_start) begin
				slave_req[tgt_idx] <= 1'b1;
				slave_cmd[tgt_idx] <= cur_cmd;
			end
			if (slave_done) begin
				slave_req[tgt_idx] <= 1'b0;  // Drop on the ack edge
			end
		end
	end

	always_ff @(posedge iClk) begin
		if (slave_start) begin
			slave_addr[tgt_idx]  <= cur_addr.fields.offset;  // Offset only, select is consumed
			slave_wdata[tgt_idx] <= cur_wdata;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/xbar_ctrl.sv ====
`default_nettype none

module xbar_ctrl (
	input  wire logic                             iClk,
	input  wire logic                             rst_n,
	input  wire logic [xbar_pkg::NUM_MASTERS-1:0] master_req,   // Raw master requests
	input  wire logic                             grant_valid,  // Arbiter has a winner
	input  wire xbar_pkg::port_idx_t              grant_idx,    // Arbiter winner
	input  wire xbar_pkg::port_idx_t              tgt_idx,      // Slave of the latched request
	input  wire logic [xbar_pkg::NUM_SLAVES-1:0]  slave_ack,    // Slave acknowledges
	output logic                                  grant_load,   // Latch the winner
	output logic                                  slave_start,  // Raise slave_req
	output logic                                  slave_done,   // Target slave answered
	output logic                                  resp_fire,    // Pulse master_ack
	output xbar_pkg::port_idx_t                   owner_idx     // Current transaction owner
);
	import xbar_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,                                    // Waiting for a request
		ST_GRANT,                                   // Request latched, slave_req goes up
		ST_BUSY,                                    // Waiting on the target slave
		ST_DONE                                     // Master ack cycle
	} state_e;

	state_e                        state;
	logic [$clog2(INIT_DELAY)-1:0] init_cnt;       // Start-up delay counter
	logic                          init_done;      // Delay elapsed, bus open

	// Hold the bus closed for INIT_DELAY cycles after reset release
	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			init_cnt  <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			if (init_cnt == INIT_DELAY - 1) begin
				init_done <= 1'b1;                  // Last delay cycle
			end
			init_cnt <= init_cnt + 1'b1;
		end
	end

	assign grant_load  = (state == ST_IDLE) && init_done && (|master_req) && grant_valid;
	assign slave_start = (state == ST_GRANT);
	// Only the addressed slave may finish the transfer
	assign slave_done  = (state == ST_BUSY) && slave_ack[tgt_idx];
	assign resp_fire   = slave_done;                // Ack register loads on the same edge

	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			owner_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant_load) begin
						state     <= ST_GRANT;
						owner_idx <= grant_idx;     // Remember who gets the answer
					end
				end
				ST_GRANT: begin
					state <= ST_BUSY;               // slave_req is up from here
				end
				ST_BUSY: begin
					if (slave_done) begin
						state <= ST_DONE;           // Back-pressure ends
					end
				end
				ST_DONE: begin
					// Owner drops its request during this cycle
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rr_arbiter.sv ====
`default_nettype none

module rr_arbiter (
	input  wire logic                             iClk,
	input  wire logic                             rst_n,
	input  wire logic [xbar_pkg::NUM_MASTERS-1:0] master_req,   // Pending requests
	input  wire logic                             grant_load,   // Winner accepted
	output logic                                  grant_valid,  // Any request pending
	output xbar_pkg::port_idx_t                   grant_idx     // Chosen master
);
	import xbar_pkg::*;

	port_idx_t last_q;      // Last master served
	port_idx_t cand;        // Index under test in the search
	logic      found;       // A requester has been picked

	// Search starts one place after the last served master and wraps
	always_comb begin
		grant_idx = last_q;
		found     = 1'b0;
		cand      = last_q;
		for (int i = 1; i <= NUM_MASTERS; i++) begin
			cand = port_idx_t'(last_q + i);
			if (!found && master_req[cand]) begin
				grant_idx = cand;
				found     = 1'b1;
			end
		end
	end

	assign grant_valid = |master_req;

	always_ff @(posedge iClk or negedge rst_n) begin
		if (!rst_n) begin
			last_q <= port_idx_t'(NUM_MASTERS - 1);  // Next search begins at master 0
		end else if (grant_load) begin
			last_q <= grant_idx;                     // Rotate priority past the winner
		end
	end

endmodule

`default_nettype wire

// ==== common/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

	localparam int NUM_MASTERS = 4;             // Masters on the shared bus
	localparam int NUM_SLAVES  = 4;             // Slaves behind the decoder
	localparam int PORT_W      = 2;             // Bits for a master or slave index

	typedef logic [PORT_W-1:0] port_idx_t;      // Master or slave number

	// Cycles after reset release before the first grant
	localparam int INIT_DELAY = 50;

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	localparam int DATA_W = 32;                 // Bus data width
	localparam int ADDR_W = 32;                 // Full master address width
	localparam int SEL_W  = 2;                  // Top bits that pick the slave
	localparam int OFS_W  = ADDR_W - SEL_W;     // Address bits passed on to the slave

	typedef logic [DATA_W-1:0] bus_data_t;      // One bus word
	typedef logic [OFS_W-1:0]  bus_offset_t;    // Slave-local address

	typedef enum logic {
		CMD_READ  = 1'b0,                       // Read from slave
		CMD_WRITE = 1'b1                        // Write to slave
	} bus_cmd_e;

	// Master address seen as select field plus offset
	typedef struct packed {
		logic [SEL_W-1:0] sel;                  // Slave select field
		bus_offset_t      offset;               // Offset inside the slave
	} bus_addr_fields_t;

	typedef union packed {
		logic [ADDR_W-1:0] raw;                 // Word as driven by the master
		bus_addr_fields_t  fields;              // Decoded view
	} bus_addr_u;

	// Select value to slave index, the highest select hits slave 0
	localparam logic [2**SEL_W-1:0][SEL_W-1:0] SEL_TO_SLAVE = {
		2'd0,                                   // sel 3
		2'd1,                                   // sel 2
		2'd2,                                   // sel 1
		2'd3                                    // sel 0
	};

endpackage

`default_nettype wire
